/* include/axil_apb_params.svh */
`ifndef AXIL_APB_PARAMS_SVH
`define AXIL_APB_PARAMS_SVH

// --------------------
// Bus widths
// --------------------

// Byte address on AXI4-Lite and APB
`define AXIL_APB_ADDR_W 12

// Data word on both sides
`define AXIL_APB_DATA_W 32

// --------------------
// Register target
// --------------------

// Words in the APB register bank
`define AXIL_APB_NUM_REGS 16

// Width of the wait-state setting
`define AXIL_APB_WAIT_W 5

// Access cycles without pready before the bridge gives up
`define AXIL_APB_TIMEOUT 20

`endif

/* hdl/axil_apb_pkg.sv */
`include "axil_apb_params.svh"

package axil_apb_pkg;

  // --------------------
  // Width types
  // --------------------

  // Byte address
  typedef logic [`AXIL_APB_ADDR_W-1:0] addr_t;
  // Data word
  typedef logic [`AXIL_APB_DATA_W-1:0] data_t;
  // One strobe bit per data byte
  typedef logic [`AXIL_APB_DATA_W/8-1:0] strb_t;
  // Protection with bit 1 set for non-secure
  typedef logic [2:0] prot_t;
  // AXI response code
  typedef logic [1:0] resp_t;
  // Wait-state count
  typedef logic [`AXIL_APB_WAIT_W-1:0] wait_t;

  localparam resp_t RESP_OKAY   = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // --------------------
  // Bridge FSM
  // --------------------

  // One-hot APB phase encoding
  typedef enum logic [3:0] {
    IDLE   = 4'b0001,
    SETUP  = 4'b0010,
    ACCESS = 4'b0100,
    RESP   = 4'b1000
  } apb_state_t;

  // Captured request as driven onto APB
  typedef struct packed {
    addr_t addr;
    data_t wdata;
    strb_t strb;
    prot_t prot;
    logic  write;
  } apb_req_t;

  // Target response
  typedef struct packed {
    data_t rdata;
    logic  slverr;
  } apb_rsp_t;

endpackage

/* hdl/rr_arb2.sv */
`timescale 1ns/10ps

module rr_arb2 (
  input  logic clk,
  input  logic rst,
  input  logic write_req,
  input  logic read_req,
  output logic write_grant,
  output logic read_grant
);

  // Set when the write side wins a tie
  logic prio_write;

  // Lone requester always wins
  // On a tie the pointer decides
  assign write_grant = write_req && (!read_req || prio_write);
  assign read_grant  = read_req && (!write_req || !prio_write);

  // Pointer moves away from whoever was just served
  always_ff @(posedge clk) begin
    if (rst) begin
      prio_write <= 1'b1;
    end else if (write_grant) begin
      prio_write <= 1'b0;
    end else if (read_grant) begin
      prio_write <= 1'b1;
    end
  end

endmodule

/* hdl/apb_fsm.sv */
`timescale 1ns/10ps

module apb_fsm
  import axil_apb_pkg::*;
(
  input  logic       clk,
  input  logic       rst,
  output apb_state_t state,
  // AXI4-Lite handshakes
  input  logic       awvalid,
  input  logic       wvalid,
  input  logic       arvalid,
  input  logic       bready,
  input  logic       rready,
  // Arbiter
  output logic       write_req,
  output logic       read_req,
  input  logic       write_grant,
  input  logic       read_grant,
  output logic       awready,
  output logic       wready,
  output logic       arready,
  output logic       bvalid,
  output logic       rvalid,
  // Captured direction
  input  logic       is_write,
  // APB progress
  input  logic       pready,
  input  logic       expired,
  output logic       psel,
  output logic       penable,
  output logic       count_en,
  output logic       rsp_load
);

  apb_state_t state_next;
  logic       rsp_done;

  // --------------------
  // Requests and AXI side
  // --------------------

  // Write needs address and data together
  assign write_req = awvalid && wvalid && (state == IDLE);
  assign read_req  = arvalid && (state == IDLE);

  // AW and W accepted in the same cycle
  assign awready = write_grant;
  assign wready  = write_grant;
  assign arready = read_grant;

  // Only one of B and R is live in RESP
  assign bvalid = (state == RESP) && is_write;
  assign rvalid = (state == RESP) && !is_write;

  assign rsp_done = (is_write && bready) || (!is_write && rready);

  // --------------------
  // APB side
  // --------------------

  assign psel     = (state == SETUP) || (state == ACCESS);
  assign penable  = (state == ACCESS);
  assign count_en = (state == ACCESS);
  // Target answered or the timer gave up
  assign rsp_load = (state == ACCESS) && (pready || expired);

  // Next state
  always_comb begin
    state_next = state;
    case (state)
      IDLE: begin
        if (write_grant || read_grant) begin
          state_next = SETUP;
        end
      end
      SETUP: begin
        state_next = ACCESS;
      end
      ACCESS: begin
        if (pready || expired) begin
          state_next = RESP;
        end
      end
      RESP: begin
        // Held here while the master back-pressures
        if (rsp_done) begin
          state_next = IDLE;
        end
      end
      default: begin
        state_next = IDLE;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      state <= IDLE;
    end else begin
      state <= state_next;
    end
  end

endmodule

/* hdl/apb_wait_timer.sv */
`timescale 1ns/10ps
`include "axil_apb_params.svh"

module apb_wait_timer
  import axil_apb_pkg::*;
(
  input  logic clk,
  input  logic rst,
  input  logic count_en,
  input  logic pready,
  output logic expired
);

  // Access cycles seen so far in this transfer
  wait_t cnt;

  // Counts only while the FSM sits in ACCESS
  always_ff @(posedge clk) begin
    if (rst || !count_en) begin
      cnt <= '0;
    end else begin
      cnt <= cnt + 1'b1;
    end
  end

  // Last allowed cycle passed with no answer
  // A late pready in that same cycle still wins
  assign expired = count_en && !pready &&
                   (cnt == wait_t'(`AXIL_APB_TIMEOUT - 1));

endmodule

/* hdl/apb_xfer_capture.sv */
`timescale 1ns/10ps

module apb_xfer_capture
  import axil_apb_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     write_grant,
  input  logic     read_grant,
  // AXI4-Lite request fields
  input  addr_t    awaddr,
  input  addr_t    araddr,
  input  prot_t    awprot,
  input  prot_t    arprot,
  input  data_t    wdata,
  input  strb_t    wstrb,
  // Request held for the APB transfer
  output apb_req_t req,
  // Response capture
  input  logic     rsp_load,
  input  logic     expired,
  input  apb_rsp_t rsp,
  output resp_t    bresp,
  output resp_t    rresp,
  output data_t    rdata
);

  apb_rsp_t rsp_q;
  resp_t    resp_code;

  // --------------------
  // Request side
  // --------------------

  // Address and protection follow the granted channel
  // Data and strobes only matter for writes
  always_ff @(posedge clk) begin
    if (write_grant || read_grant) begin
      req.addr  <= write_grant ? awaddr : araddr;
      req.prot  <= write_grant ? awprot : arprot;
      req.wdata <= wdata;
      req.strb  <= wstrb;
      req.write <= write_grant;
    end
  end

  // --------------------
  // Response side
  // --------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      rsp_q <= '0;
    end else if (rsp_load) begin
      if (expired) begin
        // Abandoned transfer carries no data
        rsp_q.slverr <= 1'b1;
        rsp_q.rdata  <= '0;
      end else begin
        rsp_q <= rsp;
      end
    end
  end

  assign resp_code = rsp_q.slverr ? RESP_SLVERR : RESP_OKAY;

  // Same code on both; the FSM picks which valid is raised
  assign bresp = resp_code;
  assign rresp = resp_code;
  assign rdata = rsp_q.rdata;

endmodule

/* hdl/apb_reg_target.sv */
`timescale 1ns/10ps
`include "axil_apb_params.svh"

module apb_reg_target
  import axil_apb_pkg::*;
(
  input  logic     clk,
  input  logic     rst,
  input  logic     psel,
  input  logic     penable,
  input  apb_req_t req,
  output logic     pready,
  output apb_rsp_t rsp
);

  localparam int WAIT_IDX   = `AXIL_APB_NUM_REGS - 1;
  localparam int SECURE_IDX = `AXIL_APB_NUM_REGS - 2;

  // Plain data words; the last index holds the wait setting instead
  data_t       bank [0:`AXIL_APB_NUM_REGS-2];
  wait_t       wait_q;
  wait_t       wait_cnt;
  wait_t       wait_eff;
  logic [3:0]  idx;
  logic        unmapped;
  logic        secure_err;
  logic        err;
  logic        in_access;
  logic        do_write;

  // --------------------
  // Decode
  // --------------------

  assign idx = req.addr[5:2];
  // Anything at 0x040 or above
  assign unmapped   = |req.addr[`AXIL_APB_ADDR_W-1:6];
  // Non-secure master touching the protected word
  assign secure_err = (idx == SECURE_IDX) && req.prot[1];
  assign err        = unmapped || secure_err;

  // Errors on unmapped space and the wait register answer at once
  assign wait_eff = (unmapped || (idx == WAIT_IDX)) ? '0 : wait_q;

  assign in_access = psel && penable;
  assign pready    = in_access && (wait_cnt == wait_eff);
  assign do_write  = pready && req.write && !err;

  // Wait cycles spent in ACCESS so far
  // A dropped psel discards the partial count
  always_ff @(posedge clk) begin
    if (rst || !psel || pready) begin
      wait_cnt <= '0;
    end else if (in_access) begin
      wait_cnt <= wait_cnt + 1'b1;
    end
  end

  // --------------------
  // Register bank
  // --------------------

  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < `AXIL_APB_NUM_REGS - 1; i++) begin
        bank[i] <= '0;
      end
      wait_q <= '0;
    end else if (do_write) begin
      if (idx == WAIT_IDX) begin
        // Wait field sits in byte 0
        if (req.strb[0]) begin
          wait_q <= req.wdata[`AXIL_APB_WAIT_W-1:0];
        end
      end else begin
        // Byte merge under strobes
        for (int b = 0; b < `AXIL_APB_DATA_W / 8; b++) begin
          if (req.strb[b]) begin
            bank[idx][8*b +: 8] <= req.wdata[8*b +: 8];
          end
        end
      end
    end
  end

  // Read data is zero on any error
  always_comb begin
    rsp.slverr = err;
    if (err) begin
      rsp.rdata = '0;
    end else if (idx == WAIT_IDX) begin
      rsp.rdata = data_t'(wait_q);
    end else begin
      rsp.rdata = bank[idx];
    end
  end

endmodule

/* hdl/axil_apb_top.sv */
`timescale 1ns/10ps

module axil_apb_top
  import axil_apb_pkg::*;
(
  input  logic  clk,
  input  logic  rst,
  // Write address
  input  addr_t awaddr,
  input  prot_t awprot,
  input  logic  awvalid,
  output logic  awready,
  // Write data
  input  data_t wdata,
  input  strb_t wstrb,
  input  logic  wvalid,
  output logic  wready,
  // Write response
  output resp_t bresp,
  output logic  bvalid,
  input  logic  bready,
  // Read address
  input  addr_t araddr,
  input  prot_t arprot,
  input  logic  arvalid,
  output logic  arready,
  // Read data
  output data_t rdata,
  output resp_t rresp,
  output logic  rvalid,
  input  logic  rready
);

  // --------------------
  // Internal nets
  // --------------------

  logic       write_req;
  logic       read_req;
  logic       write_grant;
  logic       read_grant;
  logic       psel;
  logic       penable;
  logic       pready;
  logic       count_en;
  logic       expired;
  logic       rsp_load;
  apb_req_t   apb_req;
  apb_rsp_t   apb_rsp;

  // Write or read picked when both wait in IDLE
  rr_arb2 arb0 (
    .clk         (clk),
    .rst         (rst),
    .write_req   (write_req),
    .read_req    (read_req),
    .write_grant (write_grant),
    .read_grant  (read_grant)
  );

  // Phase sequencing and AXI handshakes
  apb_fsm fsm0 (
    .clk         (clk),
    .rst         (rst),
    .state       (),
    .awvalid     (awvalid),
    .wvalid      (wvalid),
    .arvalid     (arvalid),
    .bready      (bready),
    .rready      (rready),
    .write_req   (write_req),
    .read_req    (read_req),
    .write_grant (write_grant),
    .read_grant  (read_grant),
    .awready     (awready),
    .wready      (wready),
    .arready     (arready),
    .bvalid      (bvalid),
    .rvalid      (rvalid),
    .is_write    (apb_req.write),
    .pready      (pready),
    .expired     (expired),
    .psel        (psel),
    .penable     (penable),
    .count_en    (count_en),
    .rsp_load    (rsp_load)
  );

  // Aborts a stalled ACCESS
  apb_wait_timer timer0 (
    .clk      (clk),
    .rst      (rst),
    .count_en (count_en),
    .pready   (pready),
    .expired  (expired)
  );

  // Request and response holding registers
  apb_xfer_capture cap0 (
    .clk         (clk),
    .rst         (rst),
    .write_grant (write_grant),
    .read_grant  (read_grant),
    .awaddr      (awaddr),
    .araddr      (araddr),
    .awprot      (awprot),
    .arprot      (arprot),
    .wdata       (wdata),
    .wstrb       (wstrb),
    .req         (apb_req),
    .rsp_load    (rsp_load),
    .expired     (expired),
    .rsp         (apb_rsp),
    .bresp       (bresp),
    .rresp       (rresp),
    .rdata       (rdata)
  );

  // The only APB target
  apb_reg_target tgt0 (
    .clk     (clk),
    .rst     (rst),
    .psel    (psel),
    .penable (penable),
    .req     (apb_req),
    .pready  (pready),
    .rsp     (apb_rsp)
  );

endmodule

/* bench/tb_axil_apb.sv */
`timescale 1ns/10ps
`include "axil_apb_params.svh"

module tb_axil_apb
  import axil_apb_pkg::*;
();

  localparam int CYCLE_LIMIT = 4000;
  localparam int HALF_PERIOD = 4;

  logic  clk;
  logic  rst;
  addr_t awaddr;
  prot_t awprot;
  logic  awvalid;
  logic  awready;
  data_t wdata;
  strb_t wstrb;
  logic  wvalid;
  logic  wready;
  resp_t bresp;
  logic  bvalid;
  logic  bready;
  addr_t araddr;
  prot_t arprot;
  logic  arvalid;
  logic  arready;
  data_t rdata;
  resp_t rresp;
  logic  rvalid;
  logic  rready;

  integer seed;
  int     error_count;
  int     cycle_count;
  int     tests_run;
  int     tests_failed;
  // Longest random B/R stall
  // Zero still leaves one cycle of valid before ready
  int     bp_max;
  // Enables the grant-to-response latency check
  logic   lat_check;
  // W trails AW by one cycle when set
  logic   w_lag;
  // Reference model of the plain words and the wait setting
  data_t  shadow [0:14];
  wait_t  wait_val;
  // Grant order with 0 for write and 1 for read
  int     order_q [$];

  axil_apb_top dut0 (
    .clk     (clk),
    .rst     (rst),
    .awaddr  (awaddr),
    .awprot  (awprot),
    .awvalid (awvalid),
    .awready (awready),
    .wdata   (wdata),
    .wstrb   (wstrb),
    .wvalid  (wvalid),
    .wready  (wready),
    .bresp   (bresp),
    .bvalid  (bvalid),
    .bready  (bready),
    .araddr  (araddr),
    .arprot  (arprot),
    .arvalid (arvalid),
    .arready (arready),
    .rdata   (rdata),
    .rresp   (rresp),
    .rvalid  (rvalid),
    .rready  (rready)
  );

  always #(HALF_PERIOD) clk = ~clk;

  // Watchdog
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= CYCLE_LIMIT) begin
      $display("Timeout: run did not finish within %0d cycles", CYCLE_LIMIT);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // --------------------
  // Protocol checks
  // --------------------

  // B held steady under back-pressure
  assert property (@(posedge clk) disable iff (rst)
      bvalid && !bready |=> bvalid && $stable(bresp))
    else begin
      $display("ERROR at %0t: bvalid dropped or bresp changed while bready was low", $time);
      error_count++;
    end

  // R held steady under back-pressure
  assert property (@(posedge clk) disable iff (rst)
      rvalid && !rready |=> rvalid && $stable(rresp) && $stable(rdata))
    else begin
      $display("ERROR at %0t: rvalid dropped or R payload changed while rready was low",
               $time);
      error_count++;
    end

  // Nothing new accepted while a response is pending
  assert property (@(posedge clk) disable iff (rst)
      (bvalid || rvalid) |-> !awready && !wready && !arready)
    else begin
      $display("ERROR at %0t: a request was accepted before the response handshake", $time);
      error_count++;
    end

  // Ready only alongside its valid
  assert property (@(posedge clk) disable iff (rst)
      (awready || wready) |-> awvalid && wvalid && awready && wready)
    else begin
      $display("ERROR at %0t: awready/wready high without both valids, or not paired", $time);
      error_count++;
    end

  assert property (@(posedge clk) disable iff (rst)
      arready |-> arvalid && !awready)
    else begin
      $display("ERROR at %0t: arready high without arvalid or together with awready", $time);
      error_count++;
    end

  // With 7 wait states the response rises 10 cycles after the grant
  assert property (@(posedge clk) disable iff (rst)
      lat_check && (bvalid || rvalid) && !$past(bvalid || rvalid)
        |-> $past(awready || arready, 10))
    else begin
      $display("ERROR at %0t: response did not arrive 10 cycles after the grant", $time);
      error_count++;
    end

  // --------------------
  // Helpers
  // --------------------

  function automatic int rand_below(input int n);
    return int'($unsigned($random(seed)) % n);
  endfunction

  function automatic data_t rand_word();
    return data_t'($random(seed));
  endfunction

  function automatic addr_t reg_addr(input logic [3:0] i);
    return {6'b0, i, 2'b00};
  endfunction

  function automatic void clear_model();
    for (int i = 0; i < 15; i++) begin
      shadow[i] = '0;
    end
    wait_val = '0;
  endfunction

  // Expected outcome of one access, applies writes to the shadow
  function automatic void model_access(input logic wr, input addr_t addr, input data_t data,
                                       input strb_t strb, input prot_t prot,
                                       output resp_t resp, output data_t rd);
    logic [3:0] idx;
    idx  = addr[5:2];
    resp = RESP_OKAY;
    rd   = '0;
    if (addr >= 12'h040) begin
      resp = RESP_SLVERR;
    end else if (idx == 4'd14 && prot[1]) begin
      resp = RESP_SLVERR;
    end else if (idx == 4'd15) begin
      // wait register never stalls
      if (wr && strb[0]) begin
        wait_val = data[`AXIL_APB_WAIT_W-1:0];
      end
      rd = data_t'(wait_val);
    end else if (int'(wait_val) >= `AXIL_APB_TIMEOUT) begin
      // bridge timer aborts before the target answers
      resp = RESP_SLVERR;
    end else begin
      if (wr) begin
        for (int b = 0; b < 4; b++) begin
          if (strb[b]) begin
            shadow[idx][8*b +: 8] = data[8*b +: 8];
          end
        end
      end
      rd = shadow[idx];
    end
  endfunction

  task automatic apply_reset();
    @(posedge clk);
    rst <= 1'b1;
    repeat (16) @(posedge clk);
    rst <= 1'b0;
    clear_model();
  endtask

  task automatic write_txn(input addr_t addr, input data_t data, input strb_t strb,
                           input prot_t prot, output resp_t resp);
    int stall;
    stall = (bp_max > 0) ? rand_below(bp_max + 1) : 0;
    @(posedge clk);
    awaddr  <= addr;
    awprot  <= prot;
    awvalid <= 1'b1;
    // AW alone must not be accepted
    if (w_lag) begin
      @(posedge clk);
    end
    wdata   <= data;
    wstrb   <= strb;
    wvalid  <= 1'b1;
    // Ready is seen at the negedge and the handshake lands on the next edge
    @(negedge clk);
    while (!awready) @(negedge clk);
    order_q.push_back(0);
    @(posedge clk);
    awvalid <= 1'b0;
    wvalid  <= 1'b0;
    @(negedge clk);
    while (!bvalid) @(negedge clk);
    repeat (stall) @(negedge clk);
    @(posedge clk);
    bready <= 1'b1;
    @(negedge clk);
    resp = bresp;
    @(posedge clk);
    bready <= 1'b0;
  endtask

  task automatic read_txn(input addr_t addr, input prot_t prot,
                          output resp_t resp, output data_t data);
    int stall;
    stall = (bp_max > 0) ? rand_below(bp_max + 1) : 0;
    @(posedge clk);
    araddr  <= addr;
    arprot  <= prot;
    arvalid <= 1'b1;
    @(negedge clk);
    while (!arready) @(negedge clk);
    order_q.push_back(1);
    @(posedge clk);
    arvalid <= 1'b0;
    @(negedge clk);
    while (!rvalid) @(negedge clk);
    repeat (stall) @(negedge clk);
    @(posedge clk);
    rready <= 1'b1;
    @(negedge clk);
    resp = rresp;
    data = rdata;
    @(posedge clk);
    rready <= 1'b0;
  endtask

  task automatic do_write(input addr_t addr, input data_t data, input strb_t strb,
                          input prot_t prot);
    resp_t exp_resp;
    resp_t got_resp;
    data_t ignored;
    model_access(1'b1, addr, data, strb, prot, exp_resp, ignored);
    write_txn(addr, data, strb, prot, got_resp);
    assert (got_resp == exp_resp) else begin
      $display("FAIL %0t: write 0x%03h bresp %0d, expected %0d",
               $time, addr, got_resp, exp_resp);
      error_count++;
    end
  endtask

  task automatic do_read(input addr_t addr, input prot_t prot);
    resp_t exp_resp;
    resp_t got_resp;
    data_t exp_data;
    data_t got_data;
    model_access(1'b0, addr, '0, '0, prot, exp_resp, exp_data);
    read_txn(addr, prot, got_resp, got_data);
    assert (got_resp == exp_resp) else begin
      $display("FAIL %0t: read 0x%03h rresp %0d, expected %0d",
               $time, addr, got_resp, exp_resp);
      error_count++;
    end
    assert (got_data == exp_data) else begin
      $display("FAIL %0t: read 0x%03h data 0x%08h, expected 0x%08h",
               $time, addr, got_data, exp_data);
      error_count++;
    end
  endtask

  task automatic finish_test(input string name, input int errs_before);
    tests_run++;
    if (error_count == errs_before) begin
      $display("test %0d %s: passed", tests_run, name);
    end else begin
      tests_failed++;
      $display("test %0d %s: failed, %0d errors", tests_run, name,
               error_count - errs_before);
    end
  endtask

  // --------------------
  // Test sequence
  // --------------------

  initial begin
    int         errs;
    logic [3:0] idx;
    clk = 1'b0;
    rst = 1'b1;
    awaddr = '0;
    awprot = '0;
    awvalid = 1'b0;
    wdata = '0;
    wstrb = '0;
    wvalid = 1'b0;
    bready = 1'b0;
    araddr = '0;
    arprot = '0;
    arvalid = 1'b0;
    rready = 1'b0;
    seed = 74234;
    error_count = 0;
    cycle_count = 0;
    tests_run = 0;
    tests_failed = 0;
    bp_max = 0;
    lat_check = 1'b0;
    w_lag = 1'b0;
    apply_reset();

    // Strobed random writes then a readback of everything
    errs = error_count;
    for (int n = 0; n < 40; n++) begin
      idx = 4'(rand_below(15));
      do_write(reg_addr(idx), rand_word(), strb_t'(rand_below(16)), 3'b000);
    end
    for (int i = 0; i < 15; i++) begin
      do_read(reg_addr(4'(i)), 3'b000);
    end
    finish_test("strobed writes and readback", errs);

    // Unmapped space and the secure word
    errs = error_count;
    do_write(12'h044, rand_word(), 4'hf, 3'b000);
    do_write(12'hffc, rand_word(), 4'hf, 3'b000);
    do_read(12'h080, 3'b000);
    do_read(12'h7f0, 3'b000);
    do_write(reg_addr(4'd14), rand_word(), 4'hf, 3'b010);
    do_read(reg_addr(4'd14), 3'b000);
    do_read(reg_addr(4'd14), 3'b010);
    do_write(reg_addr(4'd14), rand_word(), 4'hf, 3'b000);
    do_read(reg_addr(4'd14), 3'b000);
    finish_test("error decode", errs);

    // Seven wait states
    errs = error_count;
    do_write(reg_addr(4'd15), 32'd7, 4'h1, 3'b000);
    do_read(reg_addr(4'd15), 3'b000);
    lat_check = 1'b1;
    for (int n = 0; n < 6; n++) begin
      idx = 4'(rand_below(14));
      do_write(reg_addr(idx), rand_word(), 4'hf, 3'b000);
      do_read(reg_addr(idx), 3'b000);
    end
    lat_check = 1'b0;
    finish_test("wait states", errs);

    // Stalled target and recovery through the wait register
    errs = error_count;
    do_write(reg_addr(4'd15), 32'd25, 4'h1, 3'b000);
    do_write(reg_addr(4'd0), rand_word(), 4'hf, 3'b000);
    do_read(reg_addr(4'd0), 3'b000);
    do_write(reg_addr(4'd15), 32'd0, 4'h1, 3'b000);
    do_read(reg_addr(4'd0), 3'b000);
    finish_test("access timeout", errs);

    // Random B and R back-pressure
    errs = error_count;
    bp_max = 7;
    w_lag = 1'b1;
    for (int n = 0; n < 12; n++) begin
      idx = 4'(rand_below(14));
      do_write(reg_addr(idx), rand_word(), strb_t'(rand_below(16)), 3'b000);
      do_read(reg_addr(4'(rand_below(15))), 3'b000);
    end
    w_lag = 1'b0;
    bp_max = 0;
    finish_test("back-pressure", errs);

    // Simultaneous write and read with arbitration order from reset
    errs = error_count;
    apply_reset();
    order_q.delete();
    for (int k = 0; k < 8; k++) begin
      fork
        do_write(reg_addr(4'(k)), rand_word(), 4'hf, 3'b000);
        do_read(reg_addr(4'(k + 7)), 3'b000);
      join
      // A lone write turns the pointer so later ties go to the read side
      if (k == 0) begin
        do_write(reg_addr(4'd13), rand_word(), 4'hf, 3'b000);
      end
    end
    assert (order_q.size() == 17) else begin
      $display("FAIL %0t: saw %0d grants, expected 17", $time, order_q.size());
      error_count++;
    end
    for (int i = 0; i < order_q.size(); i++) begin
      assert (order_q[i] == i % 2) else begin
        $display("FAIL %0t: grant %0d went to the wrong side", $time, i);
        error_count++;
      end
    end
    finish_test("round-robin arbitration", errs);

    $display("%0d tests, %0d passed, %0d failed, %0d errors",
             tests_run, tests_run - tests_failed, tests_failed, error_count);
    if (error_count == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

/* flist.f */
+incdir+include
hdl/axil_apb_pkg.sv
hdl/rr_arb2.sv
hdl/apb_fsm.sv
hdl/apb_wait_timer.sv
hdl/apb_xfer_capture.sv
hdl/apb_reg_target.sv
hdl/axil_apb_top.sv
bench/tb_axil_apb.sv

/* run.sh */
#!/bin/sh
# Build and run the AXI4-Lite to APB testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
  --top-module tb_axil_apb \
  -f flist.f \
  -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

# Verdict comes from the log, not the exit status
if grep -q "FAIL: see errors above" sim.log; then
  echo "Simulation failed"
  exit 1
fi
echo "Simulation passed"
